// ==== src/rvIsaPkg.sv ====
package rvIsaPkg;

    localparam int xlen = 64;

    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opOpImmW = 7'b0011011;
    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opOpW    = 7'b0111011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;

    localparam logic [6:0] funct7Base = 7'b0000000;
    localparam logic [6:0] funct7Alt  = 7'b0100000; // sub, sra

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] immHi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } s; // also carries the B immediate
    } rvInst_t;

endpackage

// ==== src/coreCtrlPkg.sv ====
package coreCtrlPkg;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluPassB // lui
    } aluOp_t;

    typedef enum logic {
        srcARs1,
        srcAPc
    } srcASel_t;

    typedef enum logic {
        srcBRs2,
        srcBImm
    } srcBSel_t;

    typedef enum logic [1:0] {
        wbAlu,
        wbLoad,
        wbPc4
    } wbSel_t;

endpackage

// ==== src/instDecoder.sv ====
`timescale 1ns/100ps

module instDecoder
    import rvIsaPkg::*;
    import coreCtrlPkg::*;
(
    input  rvInst_t         inst,
    input  logic [xlen-1:0] rs1Val,
    input  logic [xlen-1:0] rs2Val,
    output aluOp_t          aluOp,
    output srcASel_t        srcASel,
    output srcBSel_t        srcBSel,
    output logic            wordOp,
    output logic            regWen,
    output wbSel_t          wbSel,
    output logic            memRead,
    output logic            memWrite,
    output logic [1:0]      memSize,
    output logic            memUnsigned,
    output logic            takeTarget,
    output logic            targetFromRs1
);

    logic brTaken;
    logic isImm;

    assign isImm = (inst.r.opcode == opOpImm) || (inst.r.opcode == opOpImmW);

    always_comb begin
        case (inst.r.funct3)
            3'b000:  brTaken = rs1Val == rs2Val; // beq
            3'b001:  brTaken = rs1Val != rs2Val; // bne
            3'b100:  brTaken = $signed(rs1Val) < $signed(rs2Val); // blt
            3'b101:  brTaken = $signed(rs1Val) >= $signed(rs2Val); // bge
            3'b110:  brTaken = rs1Val < rs2Val; // bltu
            3'b111:  brTaken = rs1Val >= rs2Val; // bgeu
            default: brTaken = 1'b0;
        endcase
    end

    always_comb begin
        aluOp         = aluAdd;
        srcASel       = srcARs1;
        srcBSel       = srcBImm;
        wordOp        = 1'b0;
        regWen        = 1'b0;
        wbSel         = wbAlu;
        memRead       = 1'b0;
        memWrite      = 1'b0;
        memSize       = inst.r.funct3[1:0];
        memUnsigned   = 1'b0;
        takeTarget    = 1'b0;
        targetFromRs1 = 1'b0;
        case (inst.r.opcode)
            opOp, opOpW, opOpImm, opOpImmW: begin
                regWen  = 1'b1;
                srcBSel = isImm ? srcBImm : srcBRs2;
                wordOp  = (inst.r.opcode == opOpW) || (inst.r.opcode == opOpImmW);
                case (inst.r.funct3)
                    3'b000: aluOp = (!isImm && inst.r.funct7 == funct7Alt) ? aluSub : aluAdd;
                    3'b001: aluOp = aluSll;
                    3'b010: aluOp = aluSlt;
                    3'b011: aluOp = aluSltu;
                    3'b100: aluOp = aluXor;
                    3'b101: aluOp = (inst.r.funct7[6:1] == funct7Alt[6:1]) ? aluSra : aluSrl;
                    3'b110: aluOp = aluOr;
                    default: aluOp = aluAnd;
                endcase
            end
            opLui: begin
                regWen = 1'b1;
                aluOp  = aluPassB;
            end
            opAuipc: begin
                regWen  = 1'b1;
                srcASel = srcAPc;
            end
            opLoad: begin
                regWen      = 1'b1;
                wbSel       = wbLoad;
                memRead     = 1'b1;
                memUnsigned = inst.r.funct3[2]; // lbu, lhu, lwu
            end
            opStore: begin
                memWrite = 1'b1; // address is rs1 + imm
            end
            opBranch: begin
                takeTarget = brTaken;
            end
            opJal: begin
                regWen     = 1'b1;
                wbSel      = wbPc4;
                takeTarget = 1'b1;
            end
            opJalr: begin
                regWen        = 1'b1;
                wbSel         = wbPc4;
                takeTarget    = 1'b1;
                targetFromRs1 = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// ==== src/immGen.sv ====
`timescale 1ns/100ps

module immGen
    import rvIsaPkg::*;
(
    input  rvInst_t         inst,
    output logic [xlen-1:0] imm
);

    always_comb begin
        case (inst.r.opcode)
            opStore:
                imm = {{52{inst.s.immHi[6]}}, inst.s.immHi, inst.s.immLo};
            opBranch:
                imm = {{52{inst.s.immHi[6]}}, inst.s.immLo[0], inst.s.immHi[5:0],
                       inst.s.immLo[4:1], 1'b0};
            opLui, opAuipc:
                imm = {{32{inst[31]}}, inst[31:12], 12'b0};
            opJal:
                imm = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default:
                imm = {{52{inst.i.imm12[11]}}, inst.i.imm12}; // loads, op-imm, jalr
        endcase
    end

endmodule

// ==== src/regFile.sv ====
`timescale 1ns/100ps

module regFile
    import rvIsaPkg::*;
    import coreCtrlPkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic [4:0]      rs1Addr,
    input  logic [4:0]      rs2Addr,
    input  logic [4:0]      rdAddr,
    input  logic            wen,
    input  wbSel_t          wbSel,
    input  logic [xlen-1:0] aluResult,
    input  logic [xlen-1:0] loadData,
    input  logic [xlen-1:0] pcPlus4,
    output logic [xlen-1:0] rs1Val,
    output logic [xlen-1:0] rs2Val
);

    logic [xlen-1:0] regs [1:31]; // x0 not stored
    logic [xlen-1:0] wdata;

    always_comb begin
        case (wbSel)
            wbLoad:  wdata = loadData;
            wbPc4:   wdata = pcPlus4; // link address
            default: wdata = aluResult;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst && wen && rdAddr != 5'd0) begin
            regs[rdAddr] <= wdata;
        end
    end

    assign rs1Val = (rs1Addr == 5'd0) ? '0 : regs[rs1Addr];
    assign rs2Val = (rs2Addr == 5'd0) ? '0 : regs[rs2Addr];

endmodule

// ==== src/alu.sv ====
`timescale 1ns/100ps

module alu
    import rvIsaPkg::*;
    import coreCtrlPkg::*;
(
    input  aluOp_t          op,
    input  logic            wordOp,
    input  srcASel_t        srcASel,
    input  srcBSel_t        srcBSel,
    input  logic [xlen-1:0] a, // rs1
    input  logic [xlen-1:0] b, // rs2
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] imm,
    output logic [xlen-1:0] result
);

    logic [xlen-1:0] opA;
    logic [xlen-1:0] opB;
    logic [xlen-1:0] wideRes;
    logic [31:0]     wordRes;

    assign opA = (srcASel == srcAPc) ? pc : a;
    assign opB = (srcBSel == srcBImm) ? imm : b;

    always_comb begin
        case (op)
            aluAdd:   wideRes = opA + opB;
            aluSub:   wideRes = opA - opB;
            aluSll:   wideRes = opA << opB[5:0];
            aluSlt:   wideRes = {{(xlen-1){1'b0}}, $signed(opA) < $signed(opB)};
            aluSltu:  wideRes = {{(xlen-1){1'b0}}, opA < opB};
            aluXor:   wideRes = opA ^ opB;
            aluSrl:   wideRes = opA >> opB[5:0];
            aluSra:   wideRes = $signed(opA) >>> opB[5:0];
            aluOr:    wideRes = opA | opB;
            aluAnd:   wideRes = opA & opB;
            aluPassB: wideRes = opB;
            default:  wideRes = '0;
        endcase
    end

    // W forms work on the low half, right shifts see a truncated rs1
    always_comb begin
        case (op)
            aluSll:  wordRes = opA[31:0] << opB[4:0];
            aluSrl:  wordRes = opA[31:0] >> opB[4:0];
            aluSra:  wordRes = $signed(opA[31:0]) >>> opB[4:0];
            default: wordRes = wideRes[31:0]; // addw, subw
        endcase
    end

    assign result = wordOp ? {{32{wordRes[31]}}, wordRes} : wideRes;

endmodule

// ==== src/loadStoreUnit.sv ====
`timescale 1ns/100ps

module loadStoreUnit
    import rvIsaPkg::*;
(
    input  logic            rst,
    input  logic            memRead,
    input  logic            memWrite,
    input  logic [1:0]      memSize,
    input  logic            memUnsigned,
    input  logic [xlen-1:0] addr,
    input  logic [xlen-1:0] storeVal,
    input  logic [xlen-1:0] dataRdata,
    output logic [7:0]      dataWmask,
    output logic [xlen-1:0] dataWdata,
    output logic            dataRen,
    output logic [xlen-1:0] loadData
);

    logic [2:0]      offset;
    logic [7:0]      sizeMask;
    logic [xlen-1:0] shifted;

    assign offset = addr[2:0]; // byte lane in the dword

    always_comb begin
        case (memSize)
            2'd0:    sizeMask = 8'h01;
            2'd1:    sizeMask = 8'h03;
            2'd2:    sizeMask = 8'h0f;
            default: sizeMask = 8'hff;
        endcase
    end

    assign dataWdata = storeVal << {offset, 3'b000};
    assign dataWmask = (memWrite && !rst) ? (sizeMask << offset) : 8'h00;
    assign dataRen   = memRead && !rst;
    assign shifted   = dataRdata >> {offset, 3'b000};

    always_comb begin
        case (memSize)
            2'd0:    loadData = {{56{!memUnsigned && shifted[7]}}, shifted[7:0]};
            2'd1:    loadData = {{48{!memUnsigned && shifted[15]}}, shifted[15:0]};
            2'd2:    loadData = {{32{!memUnsigned && shifted[31]}}, shifted[31:0]};
            default: loadData = shifted;
        endcase
    end

endmodule

// ==== src/pcReg.sv ====
`timescale 1ns/100ps

module pcReg
    import rvIsaPkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            takeTarget,
    input  logic            targetFromRs1,
    input  logic [xlen-1:0] imm,
    input  logic [xlen-1:0] rs1Val,
    output logic [xlen-1:0] pc,
    output logic [xlen-1:0] pcPlus4
);

    logic [xlen-1:0] jalrSum;
    logic [xlen-1:0] target;

    assign pcPlus4 = pc + 4;
    assign jalrSum = rs1Val + imm;
    assign target  = targetFromRs1 ? {jalrSum[xlen-1:1], 1'b0} : pc + imm;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= takeTarget ? target : pcPlus4;
        end
    end

endmodule

// ==== src/rvCore.sv ====
`timescale 1ns/100ps

module rvCore
    import rvIsaPkg::*;
    import coreCtrlPkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic [31:0]     instData,
    input  logic [xlen-1:0] dataRdata,
    output logic [xlen-1:0] instAddr,
    output logic [xlen-1:0] dataAddr,
    output logic [xlen-1:0] dataWdata,
    output logic [7:0]      dataWmask,
    output logic            dataRen
);

    rvInst_t         inst;
    logic [xlen-1:0] rs1Val;
    logic [xlen-1:0] rs2Val;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] aluResult;
    logic [xlen-1:0] loadData;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pcPlus4;
    aluOp_t          aluOp;
    srcASel_t        srcASel;
    srcBSel_t        srcBSel;
    wbSel_t          wbSel;
    logic            wordOp;
    logic            regWen;
    logic            memRead;
    logic            memWrite;
    logic [1:0]      memSize;
    logic            memUnsigned;
    logic            takeTarget;
    logic            targetFromRs1;

    assign inst     = instData;
    assign instAddr = pc;
    assign dataAddr = aluResult;

    instDecoder decoder (
        .inst(inst), .rs1Val(rs1Val), .rs2Val(rs2Val), .aluOp(aluOp),
        .srcASel(srcASel), .srcBSel(srcBSel), .wordOp(wordOp), .regWen(regWen),
        .wbSel(wbSel), .memRead(memRead), .memWrite(memWrite), .memSize(memSize),
        .memUnsigned(memUnsigned), .takeTarget(takeTarget), .targetFromRs1(targetFromRs1)
    );

    immGen immUnit (
        .inst(inst),
        .imm(imm)
    );

    regFile regs (
        .clk(clk), .rst(rst), .rs1Addr(inst.r.rs1), .rs2Addr(inst.r.rs2),
        .rdAddr(inst.r.rd), .wen(regWen), .wbSel(wbSel), .aluResult(aluResult),
        .loadData(loadData), .pcPlus4(pcPlus4), .rs1Val(rs1Val), .rs2Val(rs2Val)
    );

    alu aluUnit (
        .op(aluOp), .wordOp(wordOp), .srcASel(srcASel), .srcBSel(srcBSel),
        .a(rs1Val), .b(rs2Val), .pc(pc), .imm(imm), .result(aluResult)
    );

    loadStoreUnit lsu (
        .rst(rst), .memRead(memRead), .memWrite(memWrite), .memSize(memSize),
        .memUnsigned(memUnsigned), .addr(aluResult), .storeVal(rs2Val),
        .dataRdata(dataRdata), .dataWmask(dataWmask), .dataWdata(dataWdata),
        .dataRen(dataRen), .loadData(loadData)
    );

    pcReg pcUnit (
        .clk(clk), .rst(rst), .takeTarget(takeTarget), .targetFromRs1(targetFromRs1),
        .imm(imm), .rs1Val(rs1Val), .pc(pc), .pcPlus4(pcPlus4)
    );

endmodule

// ==== sim/refModelPkg.sv ====
package refModelPkg;

    import rvIsaPkg::*;

    logic [63:0] modelRegs [32];
    logic [63:0] modelPc;
    logic [63:0] dataMem [64]; // bytes 0x000..0x1ff, shared with the testbench memory
    logic        expStore;
    logic        expLoad;
    logic [63:0] expAddr;
    logic [7:0]  expMask;
    logic [63:0] expData;

    function automatic logic [63:0] fillWord(input int idx);
        return (64'h9e37_79b9_7f4a_7c15 * 64'(idx + 1)) ^ {58'b0, 6'(idx)};
    endfunction

    function automatic void resetModel();
        modelPc = '0;
        foreach (modelRegs[r])
            modelRegs[r] = '0;
        expStore = 1'b0;
        expLoad  = 1'b0;
        expAddr  = '0;
        expMask  = '0;
        expData  = '0;
    endfunction

    // RV64I integer ops, f3 selects the operation
    function automatic logic [63:0] calc(input logic [2:0] f3, input logic alt,
                                         input logic isWord, input logic [63:0] a,
                                         input logic [63:0] b);
        logic [63:0] r;
        logic [5:0]  sh;
        sh = isWord ? {1'b0, b[4:0]} : b[5:0];
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << sh;
            3'd2: r = {63'b0, $signed(a) < $signed(b)};
            3'd3: r = {63'b0, a < b};
            3'd4: r = a ^ b;
            3'd5: begin
                if (isWord && alt)
                    r = {32'b0, $signed(a[31:0]) >>> sh};
                else if (isWord)
                    r = {32'b0, a[31:0] >> sh};
                else if (alt)
                    r = $signed(a) >>> sh;
                else
                    r = a >> sh;
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        if (isWord)
            r = {{32{r[31]}}, r[31:0]};
        return r;
    endfunction

    function automatic void step(input logic [31:0] w);
        rvInst_t     in;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] immI;
        logic [63:0] res;
        logic [63:0] ea;
        logic [63:0] nextPc;
        logic        wr;
        logic        taken;
        in       = w;
        a        = modelRegs[in.r.rs1];
        b        = modelRegs[in.r.rs2];
        immI     = {{52{w[31]}}, w[31:20]};
        res      = '0;
        wr       = 1'b1;
        nextPc   = modelPc + 64'd4;
        expStore = 1'b0;
        expLoad  = 1'b0;
        case (in.r.opcode)
            opOp, opOpW:
                res = calc(in.r.funct3, w[30], in.r.opcode == opOpW, a, b);
            opOpImm, opOpImmW:
                res = calc(in.r.funct3, w[30] && in.r.funct3 == 3'd5,
                           in.r.opcode == opOpImmW, a, immI);
            opLui:
                res = {{32{w[31]}}, w[31:12], 12'h000};
            opAuipc:
                res = modelPc + {{32{w[31]}}, w[31:12], 12'h000};
            opLoad: begin
                ea      = a + immI;
                expLoad = 1'b1;
                res     = dataMem[ea[8:3]] >> {ea[2:0], 3'b000};
                case (in.r.funct3)
                    3'd0: res = {{56{res[7]}}, res[7:0]};
                    3'd1: res = {{48{res[15]}}, res[15:0]};
                    3'd2: res = {{32{res[31]}}, res[31:0]};
                    3'd4: res = {56'b0, res[7:0]};
                    3'd5: res = {48'b0, res[15:0]};
                    3'd6: res = {32'b0, res[31:0]};
                    default: ; // ld keeps the whole dword
                endcase
            end
            opStore: begin
                wr       = 1'b0;
                expStore = 1'b1;
                expAddr  = a + {{52{w[31]}}, w[31:25], w[11:7]};
                expMask  = 8'((16'd1 << (5'd1 << in.r.funct3[1:0])) - 16'd1) << expAddr[2:0];
                expData  = b << {expAddr[2:0], 3'b000};
            end
            opBranch: begin
                wr = 1'b0;
                case (in.r.funct3)
                    3'd0: taken = a == b;
                    3'd1: taken = a != b;
                    3'd4: taken = $signed(a) < $signed(b);
                    3'd5: taken = $signed(a) >= $signed(b);
                    3'd6: taken = a < b;
                    default: taken = a >= b;
                endcase
                if (taken)
                    nextPc = modelPc + {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            opJal: begin
                res    = modelPc + 64'd4;
                nextPc = modelPc + {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            opJalr: begin
                res    = modelPc + 64'd4;
                nextPc = (a + immI) & ~64'd1;
            end
            default: wr = 1'b0;
        endcase
        if (wr && in.r.rd != 5'd0)
            modelRegs[in.r.rd] = res;
        modelPc = nextPc;
    endfunction

endpackage

// ==== sim/coreTb.sv ====
`timescale 1ns/100ps

module coreTb
    import rvIsaPkg::*;
    import refModelPkg::*;
();

    localparam int numInst   = 2000;
    localparam int maxCycles = numInst + 100; // reset cycles plus margin

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] instData;
    logic [63:0] dataRdata;
    logic [63:0] instAddr;
    logic [63:0] dataAddr;
    logic [63:0] dataWdata;
    logic [7:0]  dataWmask;
    logic        dataRen;
    integer      seed;
    int          cycles = 0;

    rvCore dut_i (
        .clk(clk), .rst(rst), .instData(instData), .dataRdata(dataRdata),
        .instAddr(instAddr), .dataAddr(dataAddr), .dataWdata(dataWdata),
        .dataWmask(dataWmask), .dataRen(dataRen)
    );

    always #10 clk = ~clk;

    function automatic logic [63:0] lanes(input logic [7:0] mask);
        logic [63:0] m;
        for (int b = 0; b < 8; b++)
            m[8*b +: 8] = {8{mask[b]}};
        return m;
    endfunction

    assign dataRdata = dataMem[dataAddr[8:3]];

    always @(posedge clk) begin
        if (rst) begin
            foreach (dataMem[i])
                dataMem[i] <= fillWord(i);
        end else if (dataWmask != 8'h00) begin
            dataMem[dataAddr[8:3]] <= (dataMem[dataAddr[8:3]] & ~lanes(dataWmask))
                | (dataWdata & lanes(dataWmask));
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= maxCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", maxCycles);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    task automatic reportMismatch(input string what, input logic [63:0] expVal,
                                  input logic [63:0] actVal);
        $display("[ERROR] %0t: %s expected %h, got %h", $time, what, expVal, actVal);
        $display("Test failed");
        $fatal(1, "check failed");
    endtask

    function automatic int unsigned randBelow(input int unsigned n);
        return {$random(seed)} % n;
    endfunction

    // aligned offset from x1 = 0x100, stays inside 0x000..0x1ff
    function automatic logic [11:0] memOffset(input logic [1:0] size);
        logic [11:0] off;
        off = 12'(randBelow(512)) - 12'd256;
        return off & ~((12'd1 << size) - 12'd1);
    endfunction

    function automatic logic [31:0] randomInst();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [2:0]  f3w;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [20:0] off;
        logic [31:0] w;
        rd = 5'(randBelow(32));
        if (rd == 5'd1)
            rd = 5'd0; // x1 keeps the base address
        rs1 = 5'(randBelow(32));
        rs2 = 5'(randBelow(32));
        f3  = 3'(randBelow(8));
        f3w = (randBelow(3) == 0) ? 3'd0 : 3'd1;
        if (f3w == 3'd1 && randBelow(2) != 0)
            f3w = 3'd5;
        f7  = (randBelow(2) != 0) ? funct7Alt : funct7Base;
        imm = 12'(randBelow(4096));
        case (randBelow(12))
            0, 1: w = {(f3 == 3'd0 || f3 == 3'd5) ? f7 : funct7Base, rs2, rs1, f3, rd, opOp};
            2: w = {(f3w == 3'd1) ? funct7Base : f7, rs2, rs1, f3w, rd, opOpW};
            3, 4: begin
                if (f3 == 3'd1)
                    imm = {6'b0, imm[5:0]};
                else if (f3 == 3'd5)
                    imm = {f7[6:1], imm[5:0]};
                w = {imm, rs1, f3, rd, opOpImm};
            end
            5: begin
                if (f3w == 3'd1)
                    imm = {7'b0, imm[4:0]};
                else if (f3w == 3'd5)
                    imm = {f7, imm[4:0]};
                w = {imm, rs1, f3w, rd, opOpImmW};
            end
            6: w = {20'(randBelow(1 << 20)), rd, (randBelow(2) != 0) ? opLui : opAuipc};
            7: begin
                f3 = 3'(randBelow(7));
                w  = {memOffset(f3[1:0]), 5'd1, f3, rd, opLoad};
            end
            8, 9: begin
                f3  = 3'(randBelow(4));
                imm = memOffset(f3[1:0]);
                w   = {imm[11:5], rs2, 5'd1, f3, imm[4:0], opStore};
            end
            10: begin
                f3  = 3'(randBelow(6));
                f3  = (f3 < 3'd2) ? f3 : f3 + 3'd2;
                off = 21'(randBelow(32) * 4) - 21'd64; // targets on both sides
                w   = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opBranch};
            end
            default: begin
                off = 21'(randBelow(64) * 4) - 21'd128;
                if (randBelow(2) != 0)
                    w = {off[20], off[10:1], off[11], off[19:12], rd, opJal};
                else
                    w = {12'(randBelow(32) * 4 + randBelow(2)), 5'd1, 3'b000, rd, opJalr};
            end
        endcase
        return w;
    endfunction

    function automatic logic [31:0] nextInst(input int n);
        if (n == 0)
            return {12'h100, 5'd0, 3'b000, 5'd1, opOpImm}; // addi x1, x0, 0x100
        if (n <= 30)
            return {20'(randBelow(1 << 20)), 5'(n + 1), opLui}; // give x2..x31 a value
        return randomInst();
    endfunction

    task automatic checkIdle();
        assert (instAddr == 64'd0)
        else reportMismatch("instAddr after reset", 64'd0, instAddr);
        assert (dataWmask == 8'h00)
        else reportMismatch("dataWmask after reset", 64'd0, 64'(dataWmask));
        assert (dataRen == 1'b0)
        else reportMismatch("dataRen after reset", 64'd0, 64'(dataRen));
    endtask

    task automatic checkInst(input logic [31:0] inst);
        logic [63:0] laneMask;
        assert (instAddr == modelPc)
        else reportMismatch("instAddr", modelPc, instAddr);
        step(inst);
        laneMask = lanes(expMask);
        assert (dataRen == expLoad)
        else reportMismatch("dataRen", 64'(expLoad), 64'(dataRen));
        if (expStore) begin
            assert (dataAddr == expAddr)
            else reportMismatch("store dataAddr", expAddr, dataAddr);
            assert (dataWmask == expMask)
            else reportMismatch("store dataWmask", 64'(expMask), 64'(dataWmask));
            assert ((dataWdata & laneMask) == (expData & laneMask))
            else reportMismatch("store dataWdata", expData & laneMask, dataWdata & laneMask);
        end else begin
            assert (dataWmask == 8'h00)
            else reportMismatch("dataWmask without store", 64'd0, 64'(dataWmask));
        end
    endtask

    initial begin
        logic [31:0] inst;
        seed     = 32'h534;
        rst      = 1'b1;
        instData = 32'h0000_0013; // nop
        resetModel();
        repeat (2) begin
            @(posedge clk);
            @(negedge clk);
            checkIdle();
        end
        @(posedge clk);
        rst <= 1'b0;
        for (int n = 0; n < numInst; n++) begin
            inst = nextInst(n);
            instData <= inst;
            @(negedge clk); // outputs settled mid-cycle
            if (n == 0)
                checkIdle();
            checkInst(inst);
            @(posedge clk);
        end
        @(negedge clk);
        assert (instAddr == modelPc)
        else reportMismatch("final instAddr", modelPc, instAddr);
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== vlog.f ====
src/rvIsaPkg.sv
src/coreCtrlPkg.sv
src/instDecoder.sv
src/immGen.sv
src/regFile.sv
src/alu.sv
src/loadStoreUnit.sv
src/pcReg.sv
src/rvCore.sv
sim/refModelPkg.sv
sim/coreTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module coreTb -f vlog.f; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/VcoreTb)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1
